// ==== Bender.yml ====
package:
  name: apb_stub

sources:
  - apb_stub_pkg.sv
  - axi_skid_buffer.sv
  - apb_slave_stub.sv
  - cmd_reg_bank.sv
  - apb_stub_top.sv
  - target: test
    files:
      - tb_apb_stub.sv

// ==== apb_slave_stub.sv ====
`timescale 1ns/1ps

module apb_slave_stub (
    input  logic                    aclk,
    input  logic                    aresetn,

    // APB slave
    input  logic                    i_psel,
    input  logic                    i_penable,
    input  apb_stub_pkg::addr_t     i_paddr,
    input  logic                    i_pwrite,
    input  apb_stub_pkg::data_t     i_pwdata,
    input  apb_stub_pkg::strb_t     i_pstrb,
    input  apb_stub_pkg::prot_t     i_pprot,
    output apb_stub_pkg::data_t     o_prdata,
    output logic                    o_pslverr,
    output logic                    o_pready,

    // Command packets out
    output logic                    o_cmd_valid,
    input  logic                    i_cmd_ready,
    output apb_stub_pkg::cmd_pkt_t  o_cmd_data,

    // Response packets in
    input  logic                    i_rsp_valid,
    output logic                    o_rsp_ready,
    input  apb_stub_pkg::rsp_pkt_t  i_rsp_data
);

    import apb_stub_pkg::*;

    typedef enum logic [1:0] {
        IDLE      = 2'b01,
        XFER_DATA = 2'b10
    } apb_state_t;

    apb_state_t r_state;
    apb_state_t w_next_state;

    cmd_pkt_t   w_cmd_data;
    logic       w_cmd_push;
    logic       w_cmd_room;
    rsp_pkt_t   w_rsp_data;
    logic       w_rsp_valid;
    logic       w_rsp_pop;

    // Pack the access phase
    always_comb begin
        w_cmd_data = '0;
        w_cmd_data[CMD_WRITE_BIT]                   = i_pwrite;
        w_cmd_data[CMD_PROT_LSB +: PROT_WIDTH]      = i_pprot;
        w_cmd_data[CMD_STRB_LSB +: STRB_WIDTH]      = i_pstrb;
        w_cmd_data[CMD_ADDR_LSB +: ADDR_WIDTH]      = i_paddr;
        w_cmd_data[CMD_DATA_LSB +: DATA_WIDTH]      = i_pwdata;
    end

    axi_skid_buffer #(
        .DEPTH (SKID_DEPTH),
        .WIDTH (CMD_PKT_WIDTH)
    ) cmd_skid_i (
        .aclk       (aclk),
        .aresetn    (aresetn),
        .i_wr_valid (w_cmd_push),
        .o_wr_ready (w_cmd_room),
        .i_wr_data  (w_cmd_data),
        .o_rd_valid (o_cmd_valid),
        .i_rd_ready (i_cmd_ready),
        .o_rd_data  (o_cmd_data)
    );

    axi_skid_buffer #(
        .DEPTH (SKID_DEPTH),
        .WIDTH (RSP_PKT_WIDTH)
    ) rsp_skid_i (
        .aclk       (aclk),
        .aresetn    (aresetn),
        .i_wr_valid (i_rsp_valid),
        .o_wr_ready (o_rsp_ready),
        .i_wr_data  (i_rsp_data),
        .o_rd_valid (w_rsp_valid),
        .i_rd_ready (w_rsp_pop),
        .o_rd_data  (w_rsp_data)
    );

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            r_state <= IDLE;
        end else begin
            r_state <= w_next_state;
        end
    end

    always_comb begin
        w_next_state = r_state;
        w_cmd_push   = 1'b0;
        w_rsp_pop    = 1'b0;
        o_pready     = 1'b0;
        o_pslverr    = 1'b0;
        o_prdata     = '0;

        case (r_state)
            IDLE: begin
                if (i_psel && i_penable && w_cmd_room) begin
                    w_cmd_push   = 1'b1;
                    w_next_state = XFER_DATA;
                end
            end
            XFER_DATA: begin
                // Complete the transfer in the cycle the response shows up
                if (w_rsp_valid) begin
                    o_pready     = 1'b1;
                    o_prdata     = w_rsp_data[DATA_WIDTH-1:0];
                    o_pslverr    = w_rsp_data[RSP_ERR_BIT];
                    w_rsp_pop    = 1'b1;
                    w_next_state = IDLE;
                end
            end
            default: w_next_state = IDLE;
        endcase
    end

    // PREADY only in XFER_DATA, and only while the requester holds the access phase
    a_pready_in_xfer: assert property (@(posedge aclk) disable iff (!aresetn)
        o_pready |-> (r_state == XFER_DATA && i_psel && i_penable));

endmodule : apb_slave_stub

// ==== apb_stub_pkg.sv ====
package apb_stub_pkg;

    // Bus widths
    localparam int DATA_WIDTH = 32;
    localparam int ADDR_WIDTH = 32;
    localparam int STRB_WIDTH = DATA_WIDTH / 8;
    localparam int PROT_WIDTH = 3;

    // Entries per skid buffer
    localparam int SKID_DEPTH = 4;

    typedef logic [DATA_WIDTH-1:0] data_t;
    typedef logic [ADDR_WIDTH-1:0] addr_t;
    typedef logic [STRB_WIDTH-1:0] strb_t;
    typedef logic [PROT_WIDTH-1:0] prot_t;

    // Command packet, high to low: write, prot, strb, addr, wdata
    localparam int CMD_DATA_LSB  = 0;
    localparam int CMD_ADDR_LSB  = CMD_DATA_LSB + DATA_WIDTH;
    localparam int CMD_STRB_LSB  = CMD_ADDR_LSB + ADDR_WIDTH;
    localparam int CMD_PROT_LSB  = CMD_STRB_LSB + STRB_WIDTH;
    localparam int CMD_WRITE_BIT = CMD_PROT_LSB + PROT_WIDTH;
    localparam int CMD_PKT_WIDTH = CMD_WRITE_BIT + 1;

    // Response packet, high to low: error, rdata
    localparam int RSP_ERR_BIT   = DATA_WIDTH;
    localparam int RSP_PKT_WIDTH = RSP_ERR_BIT + 1;

    typedef logic [CMD_PKT_WIDTH-1:0] cmd_pkt_t;
    typedef logic [RSP_PKT_WIDTH-1:0] rsp_pkt_t;

    // Register bank
    localparam int NUM_REGS      = 16;
    localparam int REG_IDX_WIDTH = $clog2(NUM_REGS);
    localparam int REG_IDX_LSB   = $clog2(STRB_WIDTH);

    typedef logic [REG_IDX_WIDTH-1:0] reg_idx_t;

    // Unaligned, or beyond the 16-word window
    function automatic logic addr_error(addr_t addr);
        return (|addr[REG_IDX_LSB-1:0]) ||
               (|addr[ADDR_WIDTH-1:REG_IDX_LSB+REG_IDX_WIDTH]);
    endfunction

    function automatic reg_idx_t addr_to_idx(addr_t addr);
        return addr[REG_IDX_LSB +: REG_IDX_WIDTH];
    endfunction

endpackage : apb_stub_pkg

// ==== apb_stub_top.sv ====
`timescale 1ns/1ps

module apb_stub_top (
    input  logic                 aclk,
    input  logic                 aresetn,

    input  logic                 i_psel,
    input  logic                 i_penable,
    input  apb_stub_pkg::addr_t  i_paddr,
    input  logic                 i_pwrite,
    input  apb_stub_pkg::data_t  i_pwdata,
    input  apb_stub_pkg::strb_t  i_pstrb,
    input  apb_stub_pkg::prot_t  i_pprot,
    output apb_stub_pkg::data_t  o_prdata,
    output logic                 o_pslverr,
    output logic                 o_pready
);

    import apb_stub_pkg::*;

    logic     cmd_valid;
    logic     cmd_ready;
    cmd_pkt_t cmd_data;
    logic     rsp_valid;
    logic     rsp_ready;
    rsp_pkt_t rsp_data;

    apb_slave_stub bridge_i (
        .aclk        (aclk),
        .aresetn     (aresetn),
        .i_psel      (i_psel),
        .i_penable   (i_penable),
        .i_paddr     (i_paddr),
        .i_pwrite    (i_pwrite),
        .i_pwdata    (i_pwdata),
        .i_pstrb     (i_pstrb),
        .i_pprot     (i_pprot),
        .o_prdata    (o_prdata),
        .o_pslverr   (o_pslverr),
        .o_pready    (o_pready),
        .o_cmd_valid (cmd_valid),
        .i_cmd_ready (cmd_ready),
        .o_cmd_data  (cmd_data),
        .i_rsp_valid (rsp_valid),
        .o_rsp_ready (rsp_ready),
        .i_rsp_data  (rsp_data)
    );

    cmd_reg_bank bank_i (
        .aclk        (aclk),
        .aresetn     (aresetn),
        .i_cmd_valid (cmd_valid),
        .o_cmd_ready (cmd_ready),
        .i_cmd_data  (cmd_data),
        .o_rsp_valid (rsp_valid),
        .i_rsp_ready (rsp_ready),
        .o_rsp_data  (rsp_data)
    );

endmodule : apb_stub_top

// ==== axi_skid_buffer.sv ====
`timescale 1ns/1ps

module axi_skid_buffer #(
    parameter int DEPTH = 4,
    parameter int WIDTH = 32
) (
    input  logic             aclk,
    input  logic             aresetn,

    input  logic             i_wr_valid,
    output logic             o_wr_ready,
    input  logic [WIDTH-1:0] i_wr_data,

    output logic             o_rd_valid,
    input  logic             i_rd_ready,
    output logic [WIDTH-1:0] o_rd_data
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    logic [WIDTH-1:0] r_mem [DEPTH];
    logic [PTR_W-1:0] r_wr_ptr;
    logic [PTR_W-1:0] r_rd_ptr;
    logic [CNT_W-1:0] r_count;
    logic             w_push;
    logic             w_pop;

    assign o_wr_ready = (r_count != CNT_W'(DEPTH));
    assign o_rd_valid = (r_count != '0);
    assign o_rd_data  = r_mem[r_rd_ptr];

    assign w_push = i_wr_valid && o_wr_ready;
    assign w_pop  = o_rd_valid && i_rd_ready;

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            r_wr_ptr <= '0;
            r_rd_ptr <= '0;
            r_count  <= '0;
        end else begin
            if (w_push) begin
                r_wr_ptr <= (r_wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : r_wr_ptr + 1'b1;
            end
            if (w_pop) begin
                r_rd_ptr <= (r_rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : r_rd_ptr + 1'b1;
            end
            case ({w_push, w_pop})
                2'b10:   r_count <= r_count + 1'b1;
                2'b01:   r_count <= r_count - 1'b1;
                default: r_count <= r_count;
            endcase
        end
    end

    // Storage only
    always_ff @(posedge aclk) begin
        if (w_push) begin
            r_mem[r_wr_ptr] <= i_wr_data;
        end
    end

    // A push never lands on an entry still waiting to be read
    a_no_overwrite: assert property (@(posedge aclk) disable iff (!aresetn)
        (w_push && o_rd_valid) |-> (r_wr_ptr != r_rd_ptr));

    a_rd_stable: assert property (@(posedge aclk) disable iff (!aresetn)
        (o_rd_valid && !i_rd_ready) |=> (o_rd_valid && $stable(o_rd_data)));

endmodule : axi_skid_buffer

// ==== cmd_reg_bank.sv ====
`timescale 1ns/1ps

module cmd_reg_bank (
    input  logic                    aclk,
    input  logic                    aresetn,

    input  logic                    i_cmd_valid,
    output logic                    o_cmd_ready,
    input  apb_stub_pkg::cmd_pkt_t  i_cmd_data,

    output logic                    o_rsp_valid,
    input  logic                    i_rsp_ready,
    output apb_stub_pkg::rsp_pkt_t  o_rsp_data
);

    import apb_stub_pkg::*;

    data_t    r_regs [NUM_REGS];
    logic     r_rsp_valid;
    rsp_pkt_t r_rsp_data;

    logic     w_write;
    addr_t    w_addr;
    strb_t    w_strb;
    data_t    w_wdata;
    logic     w_err;
    reg_idx_t w_idx;
    logic     w_accept;

    // Command fields
    assign w_write = i_cmd_data[CMD_WRITE_BIT];
    assign w_strb  = i_cmd_data[CMD_STRB_LSB +: STRB_WIDTH];
    assign w_addr  = i_cmd_data[CMD_ADDR_LSB +: ADDR_WIDTH];
    assign w_wdata = i_cmd_data[CMD_DATA_LSB +: DATA_WIDTH];

    assign w_err   = addr_error(w_addr);
    assign w_idx   = addr_to_idx(w_addr);

    // One command in flight at a time
    assign o_cmd_ready = !r_rsp_valid;
    assign w_accept    = i_cmd_valid && o_cmd_ready;

    assign o_rsp_valid = r_rsp_valid;
    assign o_rsp_data  = r_rsp_data;

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                r_regs[i] <= '0;
            end
        end else if (w_accept && w_write && !w_err) begin
            for (int b = 0; b < STRB_WIDTH; b++) begin
                if (w_strb[b]) begin
                    r_regs[w_idx][b*8 +: 8] <= w_wdata[b*8 +: 8];
                end
            end
        end
    end

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            r_rsp_valid <= 1'b0;
        end else if (w_accept) begin
            r_rsp_valid <= 1'b1;
        end else if (i_rsp_ready) begin
            r_rsp_valid <= 1'b0;
        end
    end

    // Writes and errors return zero data
    always_ff @(posedge aclk) begin
        if (w_accept) begin
            r_rsp_data[RSP_ERR_BIT]      <= w_err;
            r_rsp_data[DATA_WIDTH-1:0]   <= (w_err || w_write) ? '0 : r_regs[w_idx];
        end
    end

    a_rsp_stable: assert property (@(posedge aclk) disable iff (!aresetn)
        (o_rsp_valid && !i_rsp_ready) |=> (o_rsp_valid && $stable(o_rsp_data)));

endmodule : cmd_reg_bank

// ==== sources.f ====
apb_stub_pkg.sv
axi_skid_buffer.sv
apb_slave_stub.sv
cmd_reg_bank.sv
apb_stub_top.sv
tb_apb_stub.sv

// ==== tb_apb_stub.sv ====
`timescale 1ns/1ps

module tb_apb_stub;

    localparam int CLK_PERIOD = 100;
    localparam int NUM_RANDOM = 64;

    // Write flag, address, write data, strobes, expected read data, expected error
    typedef struct packed {
        logic        wr;
        logic [31:0] addr;
        logic [31:0] data;
        logic [3:0]  strb;
        logic [31:0] exp_data;
        logic        exp_err;
    } entry_t;

    logic        aclk;
    logic        aresetn;
    logic        i_psel;
    logic        i_penable;
    logic [31:0] i_paddr;
    logic        i_pwrite;
    logic [31:0] i_pwdata;
    logic [3:0]  i_pstrb;
    logic [2:0]  i_pprot;
    logic [31:0] o_prdata;
    logic        o_pslverr;
    logic        o_pready;

    entry_t      tbl[$];
    logic [31:0] ref_regs [16];
    integer      seed = 32'hd1d2;
    int          num_tests = 0;
    int          num_errors = 0;
    bit          tbl_ready = 1'b0;

    apb_stub_top dut_i (
        .aclk      (aclk),
        .aresetn   (aresetn),
        .i_psel    (i_psel),
        .i_penable (i_penable),
        .i_paddr   (i_paddr),
        .i_pwrite  (i_pwrite),
        .i_pwdata  (i_pwdata),
        .i_pstrb   (i_pstrb),
        .i_pprot   (i_pprot),
        .o_prdata  (o_prdata),
        .o_pslverr (o_pslverr),
        .o_pready  (o_pready)
    );

    initial begin
        aclk = 1'b0;
        forever begin
            #(CLK_PERIOD / 2) aclk = ~aclk;
        end
    end

    // Unaligned, or any bit above the 16-word window
    function automatic logic is_illegal(logic [31:0] addr);
        return (addr[1:0] != 2'b00) || (addr[31:6] != 26'd0);
    endfunction

    task automatic add_entry(input logic wr, input logic [31:0] addr, input logic [31:0] data,
                             input logic [3:0] strb, input logic [31:0] exp_data,
                             input logic exp_err);
        tbl.push_back({wr, addr, data, strb, exp_data, exp_err});
    endtask

    // Setup and access phases, then wait for the single PREADY pulse
    task automatic run_transfer(input entry_t e);
        logic [31:0] got_data;
        logic        got_err;
        time         t_done;
        int          errs_before;
        errs_before = num_errors;
        @(posedge aclk);
        i_psel    <= 1'b1;
        i_penable <= 1'b0;
        i_pwrite  <= e.wr;
        i_paddr   <= e.addr;
        i_pwdata  <= e.data;
        i_pstrb   <= e.strb;
        @(posedge aclk);
        i_penable <= 1'b1;
        do begin
            @(negedge aclk);
        end while (!o_pready);
        got_data = o_prdata;
        got_err  = o_pslverr;
        t_done   = $time;
        @(posedge aclk);
        i_psel    <= 1'b0;
        i_penable <= 1'b0;
        @(negedge aclk);
        num_tests++;
        assert (!o_pready) else begin
            $display("PREADY stayed high for more than one cycle at %0t", $time);
            num_errors++;
        end
        assert (got_err == e.exp_err) else begin
            $display("[ERROR] %0t o_pslverr expected %0b got %0b", t_done, e.exp_err, got_err);
            num_errors++;
        end
        if (!e.wr) begin
            assert (got_data == e.exp_data) else begin
                $display("[ERROR] %0t o_prdata expected %h got %h", t_done, e.exp_data, got_data);
                num_errors++;
            end
        end
        // Keep the reference model in step with legal writes
        if (e.wr && !is_illegal(e.addr)) begin
            for (int b = 0; b < 4; b++) begin
                if (e.strb[b]) begin
                    ref_regs[e.addr[5:2]][b*8 +: 8] = e.data[b*8 +: 8];
                end
            end
        end
        $display("test %0d %s addr %h: %s", num_tests, e.wr ? "write" : "read", e.addr,
                 (num_errors == errs_before) ? "ok" : "FAIL");
    endtask

    initial begin
        logic [31:0] pick;
        logic [31:0] addr;
        logic [31:0] data;
        logic        wr;
        logic        err;
        aresetn   <= 1'b0;
        i_psel    <= 1'b0;
        i_penable <= 1'b0;
        i_paddr   <= '0;
        i_pwrite  <= 1'b0;
        i_pwdata  <= '0;
        i_pstrb   <= '0;
        i_pprot   <= '0;
        for (int i = 0; i < 16; i++) begin
            ref_regs[i] = '0;
            add_entry(1'b0, 32'(i * 4), '0, '0, '0, 1'b0);
        end
        add_entry(1'b1, 32'h00, 32'hdeadbeef, 4'hf, '0, 1'b0);
        add_entry(1'b0, 32'h00, '0, '0, 32'hdeadbeef, 1'b0);
        add_entry(1'b1, 32'h3c, 32'h12345678, 4'hf, '0, 1'b0);
        add_entry(1'b0, 32'h3c, '0, '0, 32'h12345678, 1'b0);
        // Partial strobes merge with the old bytes
        add_entry(1'b1, 32'h00, 32'h11223344, 4'b0101, '0, 1'b0);
        add_entry(1'b0, 32'h00, '0, '0, 32'hde22be44, 1'b0);
        add_entry(1'b1, 32'h3c, 32'haabbccdd, 4'b1000, '0, 1'b0);
        add_entry(1'b0, 32'h3c, '0, '0, 32'haa345678, 1'b0);
        add_entry(1'b1, 32'h04, 32'hcafef00d, 4'b0011, '0, 1'b0);
        add_entry(1'b0, 32'h04, '0, '0, 32'h0000f00d, 1'b0);
        // Illegal addresses alias registers 0 and 15
        add_entry(1'b1, 32'h02, 32'hffffffff, 4'hf, '0, 1'b1);
        add_entry(1'b0, 32'h02, '0, '0, '0, 1'b1);
        add_entry(1'b0, 32'h00, '0, '0, 32'hde22be44, 1'b0);
        add_entry(1'b1, 32'h40, 32'hffffffff, 4'hf, '0, 1'b1);
        add_entry(1'b0, 32'h40, '0, '0, '0, 1'b1);
        add_entry(1'b0, 32'h00, '0, '0, 32'hde22be44, 1'b0);
        add_entry(1'b1, 32'h1000003c, 32'h0, 4'hf, '0, 1'b1);
        add_entry(1'b0, 32'h3c, '0, '0, 32'haa345678, 1'b0);
        add_entry(1'b0, 32'h01, '0, '0, '0, 1'b1);
        tbl_ready = 1'b1;

        repeat (2) @(posedge aclk);
        aresetn <= 1'b1;

        foreach (tbl[i]) begin
            run_transfer(tbl[i]);
        end

        for (int i = 0; i < NUM_RANDOM; i++) begin
            pick = $random(seed);
            addr = {26'd0, pick[11:8], 2'b00};
            // Roughly one in four addresses is illegal
            if (pick[1:0] == 2'b00) begin
                if (pick[2]) begin
                    addr = addr | (32'h40 << (pick[7:3] % 26));
                end else begin
                    addr = addr | {30'd0, (pick[4:3] == 2'b00) ? 2'b11 : pick[4:3]};
                end
            end
            wr   = pick[12];
            data = $random(seed);
            err  = is_illegal(addr);
            run_transfer({wr, addr, data, pick[16:13],
                          (wr || err) ? 32'h0 : ref_regs[addr[5:2]], err});
        end

        $display("%0d tests run, %0d errors", num_tests, num_errors);
        if (num_errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

    initial begin
        wait (tbl_ready);
        #((tbl.size() + NUM_RANDOM) * 20 * CLK_PERIOD);
        $display("Watchdog timeout, the transfers did not finish in time");
        $display("tests failed");
        $finish;
    end

endmodule : tb_apb_stub
